// File: Makefile
# Verilator lint and simulation of the isogeny APB bridge
VERILATOR  := verilator
TOP        := tb_isog_apb_bridge
FILELIST   := verilog.f
LINT_FLAGS := --lint-only --timing -Wall -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/isog_bridge_config.svh
//--------------------------------------------------------------------------
// isogeny bridge configuration
// bus, operand and bank geometry shared by the APB bridge blocks
//--------------------------------------------------------------------------
`ifndef ISOG_BRIDGE_CONFIG_SVH
`define ISOG_BRIDGE_CONFIG_SVH

// APB data bus width
`define APB_DATA_W 32

// one operand word is two bus words
`define OPERAND_W 64

// words per operand bank
`define BANK_DEPTH 4
`define BANK_ADDR_W 2

// byte offset width on the APB side
`define APB_ADDR_W 8

`endif

// File: sim/tb_isog_apb_bridge.sv
//--------------------------------------------------------------------------
// isogeny APB bridge testbench
// directed APB tests with a small engine model on the bank port
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "isog_bridge_config.svh"

module tb_isog_apb_bridge;
  import isog_bridge_pkg::*;

  logic                    io_mainClk = 1'b0;
  logic                    io_systemReset;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`APB_ADDR_W-1:0]  paddr;
  logic [`APB_DATA_W-1:0]  pwdata;
  logic [`APB_DATA_W-1:0]  prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    engine_rst;
  logic                    engine_start;
  logic [7:0]              engine_command;
  logic [15:0]             engine_num_loops;
  logic                    engine_busy;
  logic                    engine_done;
  logic                    engine_wr_en;
  bank_sel_e               engine_wr_sel;
  logic [`BANK_ADDR_W-1:0] engine_wr_addr;
  logic [`OPERAND_W-1:0]   engine_wr_data;
  bank_sel_e               engine_rd_sel;
  logic [`BANK_ADDR_W-1:0] engine_rd_addr;
  logic [`OPERAND_W-1:0]   engine_rd_data;
  logic [`APB_DATA_W-1:0]  unused_rdata;
  integer                  seed = 32'h42c840cb;

  always #2 io_mainClk = ~io_mainClk;

  isog_apb_bridge u_dut (.*);

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // setup phase, then access phase held until pready
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    @(posedge io_mainClk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge io_mainClk);
    penable <= 1'b1;
    for (n = 0; n < 16; n++) begin
      @(negedge io_mainClk);
      if (pready) break;
    end
    if (n == 16) stop_on_timeout("pready");
    rdata = prdata;
    check_value("apb pslverr", 64'd0, 64'(pslverr));
    @(posedge io_mainClk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // operand offsets are word spaced from X_0 in bank order
  function automatic logic [7:0] bank_offset(input int b);
    return 8'(int'(REG_X_0) + 4 * b);
  endfunction

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic write_word(input int b, input logic [63:0] w);
    apb_access(1'b1, bank_offset(b), w[31:0], unused_rdata);
    apb_access(1'b1, bank_offset(b), w[63:32], unused_rdata);
  endtask

  task automatic expect_word(input string name, input int b, input logic [63:0] w);
    logic [31:0] lo;
    logic [31:0] hi;
    apb_access(1'b0, bank_offset(b), 32'd0, lo);
    apb_access(1'b0, bank_offset(b), 32'd0, hi);
    check_value({name, " low"}, 64'(w[31:0]), 64'(lo));
    check_value({name, " high"}, 64'(w[63:32]), 64'(hi));
  endtask

  // engine model, bank port side
  task automatic engine_read(input bank_sel_e sel, input int addr, output logic [63:0] data);
    @(posedge io_mainClk);
    engine_rd_sel  <= sel;
    engine_rd_addr <= addr[`BANK_ADDR_W-1:0];
    @(negedge io_mainClk);
    data = engine_rd_data;
  endtask

  task automatic engine_write(input bank_sel_e sel, input int addr, input logic [63:0] data);
    @(posedge io_mainClk);
    engine_wr_en   <= 1'b1;
    engine_wr_sel  <= sel;
    engine_wr_addr <= addr[`BANK_ADDR_W-1:0];
    engine_wr_data <= data;
    @(posedge io_mainClk);
    engine_wr_en <= 1'b0;
  endtask

  //--------------------------------------------------------------------------
  // directed tests
  //--------------------------------------------------------------------------
  task automatic round_trip();
    logic [63:0] words [4];
    int i;
    apb_access(1'b1, REG_CTRL, 32'h1, unused_rdata);
    for (i = 0; i < 4; i++) begin
      words[i] = random_word();
      write_word(0, words[i]);
    end
    for (i = 0; i < 4; i++) begin
      expect_word($sformatf("round_trip word %0d", i), 0, words[i]);
    end
  endtask

  task automatic bank_isolation();
    logic [63:0] words [8][4];
    int b;
    int i;
    apb_access(1'b1, REG_CTRL, 32'h1, unused_rdata);
    for (b = 0; b < 8; b++) begin
      for (i = 0; i < 4; i++) begin
        words[b][i] = random_word();
        write_word(b, words[b][i]);
      end
    end
    for (b = 0; b < 8; b++) begin
      for (i = 0; i < 4; i++) begin
        expect_word($sformatf("isolation bank %0d word %0d", b, i), b, words[b][i]);
      end
    end
    // both addresses wrapped back to 0, fifth word lands on word 0
    words[5][0] = random_word();
    write_word(5, words[5][0]);
    expect_word("wrap bank 5 word 0", 5, words[5][0]);
  endtask

  task automatic control_pulses();
    logic [2:0]  seen;
    logic [31:0] loops;
    int n;
    apb_access(1'b1, REG_CTRL, {16'd0, 8'(CMD_XDBLE), 8'h02}, unused_rdata);
    for (n = 0; n < 3; n++) begin
      @(negedge io_mainClk);
      seen[n] = engine_start;
    end
    check_value("control start pulse", 64'b001, 64'(seen));
    check_value("control command", 64'd1, 64'(engine_command));
    loops = $random(seed);
    apb_access(1'b1, REG_LOOPS, loops, unused_rdata);
    @(negedge io_mainClk);
    check_value("control num_loops", 64'(loops[15:0]), 64'(engine_num_loops));
    apb_access(1'b1, REG_CTRL, 32'h1, unused_rdata);
    for (n = 0; n < 3; n++) begin
      @(negedge io_mainClk);
      seen[n] = engine_rst;
    end
    check_value("control rst pulse", 64'b001, 64'(seen));
  endtask

  task automatic busy_status();
    logic [31:0] status;
    @(posedge io_mainClk);
    engine_busy <= 1'b1;
    apb_access(1'b0, REG_CTRL, 32'd0, status);
    check_value("status while busy", 64'd1, 64'(status));
    @(posedge io_mainClk);
    engine_busy <= 1'b0;
    apb_access(1'b0, REG_CTRL, 32'd0, status);
    check_value("status after busy", 64'd0, 64'(status));
  endtask

  task automatic engine_port();
    logic [63:0] operands [4];
    logic [63:0] results [4];
    logic [63:0] seen;
    logic [31:0] half;
    int i;
    apb_access(1'b1, REG_CTRL, 32'h1, unused_rdata);
    for (i = 0; i < 4; i++) begin
      operands[i] = random_word();
      write_word(4, operands[i]);
    end
    for (i = 0; i < 4; i++) begin
      engine_read(BANK_A24_0, i, seen);
      check_value($sformatf("engine read word %0d", i), operands[i], seen);
    end
    for (i = 0; i < 4; i++) begin
      results[i] = random_word();
      engine_write(BANK_Z_1, i, results[i]);
    end
    // move the read address and toggle off zero before done
    expect_word("engine operand word 0", 4, operands[0]);
    apb_access(1'b0, REG_A24_0, 32'd0, half);
    check_value("engine low half before done", 64'(operands[1][31:0]), 64'(half));
    @(posedge io_mainClk);
    engine_done <= 1'b1;
    @(posedge io_mainClk);
    engine_done <= 1'b0;
    for (i = 0; i < 4; i++) begin
      expect_word($sformatf("engine result word %0d", i), 3, results[i]);
    end
  endtask

  task automatic packing_reset();
    logic [63:0] fresh;
    logic [63:0] seen;
    apb_access(1'b1, REG_CTRL, 32'h1, unused_rdata);
    // one full word moves the write address off 0, then a stray half
    write_word(6, random_word());
    apb_access(1'b1, REG_C24_0, $random(seed), unused_rdata);
    apb_access(1'b1, REG_CTRL, 32'h1, unused_rdata);
    fresh = random_word();
    write_word(6, fresh);
    engine_read(BANK_C24_0, 0, seen);
    check_value("packing reset engine view", fresh, seen);
    expect_word("packing reset word 0", 6, fresh);
  endtask

  initial begin
    io_systemReset = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    engine_busy    = 1'b0;
    engine_done    = 1'b0;
    engine_wr_en   = 1'b0;
    engine_wr_sel  = BANK_X_0;
    engine_wr_addr = '0;
    engine_wr_data = '0;
    engine_rd_sel  = BANK_X_0;
    engine_rd_addr = '0;
    repeat (2) @(posedge io_mainClk);
    io_systemReset <= 1'b0;
    round_trip();
    bank_isolation();
    control_pulses();
    busy_status();
    engine_port();
    packing_reset();
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin : watchdog
    int cycles;
    for (cycles = 0; cycles < 100000; cycles++) begin
      @(posedge io_mainClk);
    end
    stop_on_timeout("the test sequence to finish");
  end

endmodule

// File: verilog.f
+incdir+include
verilog/isog_bridge_pkg.sv
verilog/bank_access_if.sv
verilog/apb_reg_decode.sv
verilog/operand_bank.sv
verilog/result_read_mux.sv
verilog/isog_apb_bridge.sv
sim/tb_isog_apb_bridge.sv

// File: verilog/apb_reg_decode.sv
//--------------------------------------------------------------------------
// APB write decode
// control and loop registers, 32-to-64 bit packing of operand writes
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "isog_bridge_config.svh"

module apb_reg_decode (
  input  logic                   io_mainClk,
  input  logic                   io_systemReset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic [`APB_DATA_W-1:0] pwdata,
  input  logic                   engine_done,
  output logic                   engine_rst,
  output logic                   engine_start,
  output logic [7:0]             engine_command,
  output logic [15:0]            engine_num_loops,
  bank_access_if.decode          bank
);
  import isog_bridge_pkg::*;

  logic                    do_write;
  logic                    data_write;
  logic                    wr_half;
  logic                    wr_en_q;
  logic [`BANK_ADDR_W-1:0] wr_addr_q;
  logic [`APB_DATA_W-1:0]  low_half;
  logic [`OPERAND_W-1:0]   wr_data_q;
  bank_sel_e               wr_sel_q;

  // no wait states, so the access phase always completes
  assign do_write   = psel && penable && pwrite;
  assign data_write = do_write && is_data_offset(paddr);

  //--------------------------------------------------------------------------
  // control state
  //--------------------------------------------------------------------------
  always_ff @(posedge io_mainClk or posedge io_systemReset) begin
    if (io_systemReset) begin
      engine_rst       <= 1'b0;
      engine_start     <= 1'b0;
      engine_command   <= 8'd0;
      engine_num_loops <= 16'd0;
      wr_half          <= 1'b0;
      wr_en_q          <= 1'b0;
      wr_addr_q        <= '0;
    end else begin
      engine_rst   <= 1'b0;
      engine_start <= 1'b0;
      wr_en_q      <= 1'b0;

      if (do_write) begin
        case (paddr)
          REG_CTRL: begin
            engine_rst     <= pwdata[0];
            engine_start   <= pwdata[1];
            engine_command <= pwdata[15:8];
          end
          REG_LOOPS: begin
            engine_num_loops <= pwdata[15:0];
          end
          default: ;
        endcase
      end

      // second half of a pair commits the word
      if (engine_rst || engine_done) begin
        wr_half <= 1'b0;
      end else if (data_write) begin
        wr_half <= ~wr_half;
        wr_en_q <= wr_half;
      end

      if (engine_rst) begin
        wr_addr_q <= '0;
      end else if (wr_en_q) begin
        wr_addr_q <= (wr_addr_q == `BANK_DEPTH - 1) ? '0 : wr_addr_q + 1'b1;
      end
    end
  end

  // payload capture
  always_ff @(posedge io_mainClk) begin
    if (data_write && !wr_half) begin
      low_half <= pwdata;
    end
    if (data_write && wr_half) begin
      wr_data_q <= {pwdata, low_half};
      wr_sel_q  <= offset_to_bank(paddr);
    end
  end

  assign bank.wr_en   = wr_en_q;
  assign bank.wr_sel  = wr_sel_q;
  assign bank.wr_addr = wr_addr_q;
  assign bank.wr_data = wr_data_q;

  // control pulses come from a separate transfer than any commit
  a_ctrl_vs_commit: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    (engine_start || engine_rst) |-> !bank.wr_en)
    else $error("control pulse overlaps a bank commit");

  a_wr_addr_range: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    bank.wr_addr < `BANK_DEPTH)
    else $error("write address out of bank range");

endmodule

// File: verilog/bank_access_if.sv
//--------------------------------------------------------------------------
// bank access interface
// packed 64-bit write requests and half-word read requests to the banks
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "isog_bridge_config.svh"

interface bank_access_if;
  import isog_bridge_pkg::*;

  // write side
  logic                    wr_en;
  bank_sel_e               wr_sel;
  logic [`BANK_ADDR_W-1:0] wr_addr;
  logic [`OPERAND_W-1:0]   wr_data;

  // read side
  bank_sel_e               rd_sel;
  logic [`BANK_ADDR_W-1:0] rd_addr;
  logic [`OPERAND_W-1:0]   rd_data;

  modport decode (output wr_en, output wr_sel, output wr_addr, output wr_data);

  modport read_mux (output rd_sel, output rd_addr, input rd_data);

  modport bank (
    input  wr_en, input wr_sel, input wr_addr, input wr_data,
    input  rd_sel, input rd_addr,
    output rd_data
  );

endinterface

// File: verilog/isog_apb_bridge.sv
//--------------------------------------------------------------------------
// isogeny APB bridge top
// APB3 slave with operand banks and a port for the external engine
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "isog_bridge_config.svh"

module isog_apb_bridge (
  input  logic                       io_mainClk,
  input  logic                       io_systemReset,
  // APB3 slave
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_ADDR_W-1:0]     paddr,
  input  logic [`APB_DATA_W-1:0]     pwdata,
  output logic [`APB_DATA_W-1:0]     prdata,
  output logic                       pready,
  output logic                       pslverr,
  // engine control
  output logic                       engine_rst,
  output logic                       engine_start,
  output logic [7:0]                 engine_command,
  output logic [15:0]                engine_num_loops,
  input  logic                       engine_busy,
  input  logic                       engine_done,
  // engine bank port
  input  logic                       engine_wr_en,
  input  isog_bridge_pkg::bank_sel_e engine_wr_sel,
  input  logic [`BANK_ADDR_W-1:0]    engine_wr_addr,
  input  logic [`OPERAND_W-1:0]      engine_wr_data,
  input  isog_bridge_pkg::bank_sel_e engine_rd_sel,
  input  logic [`BANK_ADDR_W-1:0]    engine_rd_addr,
  output logic [`OPERAND_W-1:0]      engine_rd_data
);

  // zero wait state slave, never errors
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

  bank_access_if u_bank_if ();

  apb_reg_decode u_decode (
    .io_mainClk       (io_mainClk),
    .io_systemReset   (io_systemReset),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .engine_done      (engine_done),
    .engine_rst       (engine_rst),
    .engine_start     (engine_start),
    .engine_command   (engine_command),
    .engine_num_loops (engine_num_loops),
    .bank             (u_bank_if.decode)
  );

  operand_bank u_bank (
    .io_mainClk     (io_mainClk),
    .io_systemReset (io_systemReset),
    .bank           (u_bank_if.bank),
    .engine_wr_en   (engine_wr_en),
    .engine_wr_sel  (engine_wr_sel),
    .engine_wr_addr (engine_wr_addr),
    .engine_wr_data (engine_wr_data),
    .engine_rd_sel  (engine_rd_sel),
    .engine_rd_addr (engine_rd_addr),
    .engine_rd_data (engine_rd_data)
  );

  result_read_mux u_read_mux (
    .io_mainClk     (io_mainClk),
    .io_systemReset (io_systemReset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .engine_busy    (engine_busy),
    .engine_done    (engine_done),
    .engine_rst     (engine_rst),
    .prdata         (prdata),
    .bank           (u_bank_if.read_mux)
  );

endmodule

// File: verilog/isog_bridge_pkg.sv
//--------------------------------------------------------------------------
// isogeny bridge package
// register map, bank selects, engine commands and offset decode helpers
//--------------------------------------------------------------------------
package isog_bridge_pkg;

  typedef enum logic [7:0] {
    REG_CTRL  = 8'h04,
    REG_LOOPS = 8'h08,
    REG_X_0   = 8'h10,
    REG_X_1   = 8'h14,
    REG_Z_0   = 8'h18,
    REG_Z_1   = 8'h1C,
    REG_A24_0 = 8'h20,
    REG_A24_1 = 8'h24,
    REG_C24_0 = 8'h28,
    REG_C24_1 = 8'h2C
  } reg_map_e;

  typedef enum logic [2:0] {
    BANK_X_0, BANK_X_1, BANK_Z_0, BANK_Z_1,
    BANK_A24_0, BANK_A24_1, BANK_C24_0, BANK_C24_1
  } bank_sel_e;

  localparam int NUM_BANKS = 8;

  // forwarded to the engine as is
  typedef enum logic [7:0] {
    CMD_XDBLE           = 8'd1,
    CMD_GET_EVAL_4_ISOG = 8'd2,
    CMD_EVAL_4_ISOG     = 8'd3,
    CMD_XDBLADD         = 8'd4
  } engine_cmd_e;

  function automatic logic is_data_offset(input logic [7:0] addr);
    return (addr >= REG_X_0) && (addr <= REG_C24_1) && (addr[1:0] == 2'b00);
  endfunction

  // data offsets are word spaced from REG_X_0, in bank order
  function automatic bank_sel_e offset_to_bank(input logic [7:0] addr);
    logic [7:0] idx;
    idx = addr - REG_X_0;
    return bank_sel_e'(idx[4:2]);
  endfunction

endpackage

// File: verilog/operand_bank.sv
//--------------------------------------------------------------------------
// operand banks
// eight 64-bit memories, APB write port has priority over the engine
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "isog_bridge_config.svh"

module operand_bank (
  input  logic                     io_mainClk,
  input  logic                     io_systemReset,
  bank_access_if.bank              bank,
  input  logic                     engine_wr_en,
  input  isog_bridge_pkg::bank_sel_e engine_wr_sel,
  input  logic [`BANK_ADDR_W-1:0]  engine_wr_addr,
  input  logic [`OPERAND_W-1:0]    engine_wr_data,
  input  isog_bridge_pkg::bank_sel_e engine_rd_sel,
  input  logic [`BANK_ADDR_W-1:0]  engine_rd_addr,
  output logic [`OPERAND_W-1:0]    engine_rd_data
);
  import isog_bridge_pkg::*;

  logic [`OPERAND_W-1:0] apb_dout [NUM_BANKS];
  logic [`OPERAND_W-1:0] eng_dout [NUM_BANKS];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [`OPERAND_W-1:0] mem [`BANK_DEPTH];
    logic                  apb_hit;
    logic                  eng_hit;

    assign apb_hit = bank.wr_en && (bank.wr_sel == bank_sel_e'(b));
    assign eng_hit = engine_wr_en && (engine_wr_sel == bank_sel_e'(b));

    // single write port per bank
    always_ff @(posedge io_mainClk) begin
      if (apb_hit) begin
        mem[bank.wr_addr] <= bank.wr_data;
      end else if (eng_hit) begin
        mem[engine_wr_addr] <= engine_wr_data;
      end
    end

    assign apb_dout[b] = mem[bank.rd_addr];
    assign eng_dout[b] = mem[engine_rd_addr];
  end

  //--------------------------------------------------------------------------
  // read ports
  //--------------------------------------------------------------------------
  assign bank.rd_data   = apb_dout[bank.rd_sel];
  assign engine_rd_data = eng_dout[engine_rd_sel];

  a_apb_sel_valid: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    bank.wr_en |-> (bank.wr_sel inside {BANK_X_0, BANK_X_1, BANK_Z_0, BANK_Z_1,
                                        BANK_A24_0, BANK_A24_1, BANK_C24_0, BANK_C24_1}))
    else $error("APB commit with undefined bank select");

  a_eng_sel_valid: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    engine_wr_en |-> (engine_wr_sel inside {BANK_X_0, BANK_X_1, BANK_Z_0, BANK_Z_1,
                                            BANK_A24_0, BANK_A24_1, BANK_C24_0,
                                            BANK_C24_1}))
    else $error("engine write with undefined bank select");

endmodule

// File: verilog/result_read_mux.sv
//--------------------------------------------------------------------------
// APB read path
// steps the shared read address and returns operand halves or status
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "isog_bridge_config.svh"

module result_read_mux (
  input  logic                   io_mainClk,
  input  logic                   io_systemReset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic                   engine_busy,
  input  logic                   engine_done,
  input  logic                   engine_rst,
  output logic [`APB_DATA_W-1:0] prdata,
  bank_access_if.read_mux        bank
);
  import isog_bridge_pkg::*;

  logic                    do_read;
  logic                    data_read;
  logic                    rd_half;
  logic [`BANK_ADDR_W-1:0] rd_addr_q;

  assign do_read   = psel && penable && !pwrite;
  assign data_read = do_read && is_data_offset(paddr);

  assign bank.rd_sel  = offset_to_bank(paddr);
  assign bank.rd_addr = rd_addr_q;

  //--------------------------------------------------------------------------
  // half toggle and read address
  //--------------------------------------------------------------------------
  always_ff @(posedge io_mainClk or posedge io_systemReset) begin
    if (io_systemReset) begin
      rd_half   <= 1'b0;
      rd_addr_q <= '0;
    end else if (engine_rst || engine_done) begin
      rd_half   <= 1'b0;
      rd_addr_q <= '0;
    end else if (data_read) begin
      rd_half <= ~rd_half;
      // step only after the high half went out
      if (rd_half) begin
        rd_addr_q <= (rd_addr_q == `BANK_DEPTH - 1) ? '0 : rd_addr_q + 1'b1;
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (do_read) begin
      if (paddr == REG_CTRL) begin
        prdata = {{(`APB_DATA_W - 1){1'b0}}, engine_busy};
      end else if (data_read) begin
        prdata = rd_half ? bank.rd_data[`OPERAND_W-1:`APB_DATA_W]
                         : bank.rd_data[`APB_DATA_W-1:0];
      end
    end
  end

endmodule
